// ==== common/inouttraffic_cfg.svh ====
`ifndef INOUTTRAFFIC_CFG_SVH
`define INOUTTRAFFIC_CFG_SVH

// ********************
// fifo sizing, in 16-bit words
// ********************
`define INPUT_FIFO_DEPTH	16
`define OUTPUT_FIFO_DEPTH	32

// mix pipeline depth, one round per stage
`define MIX_ROUNDS	4
// room for the words in flight plus one trailer
`define OUTPUT_PROG_FREE	(`MIX_ROUNDS + 3)

// header type byte that carries data
`define PKT_TYPE_DATA	8'h01

// ********************
// vendor command/request register map
// ********************
`define VCR_ADDR_HS_EN	8'h01
`define VCR_ADDR_KEY_LO	8'h02
`define VCR_ADDR_KEY_HI	8'h03
`define VCR_ADDR_STATUS	8'h10
`define VCR_ADDR_PKT_COUNT	8'h11

`endif

// ==== common/inouttraffic_pkg.sv ====
package inouttraffic_pkg;

	// ********************
	// data widths
	// ********************

	// host link word, also the width through the whole pipeline
	typedef logic [15:0] word_t;

	// one vcr register value
	typedef logic [7:0] byte_t;

	// payload length from the header low byte
	typedef logic [7:0] pkt_len_t;

	// vcr address latch
	typedef logic [7:0] vcr_addr_t;

	// mixing key, two vcr bytes
	typedef logic [15:0] key_t;

	// ********************
	// packet parser fsm
	// ********************
	typedef enum logic [1:0] {
		PS_HEADER,	// waiting for type/length word
		PS_PAYLOAD,	// forwarding data words
		PS_DISCARD	// swallowing a bad packet
	} parser_state_e;

endpackage

// ==== hw/hs_io/hs_input_fifo.sv ====
`timescale 1ns/1ns
`include "inouttraffic_cfg.svh"

module hs_input_fifo (
	input logic ifclk,
	input logic rst_n,
	input logic hs_en,	// from vcr
	input inouttraffic_pkg::word_t fifo_din,
	input logic fifo_wr,
	output logic fifo_full,
	output inouttraffic_pkg::word_t in_word,
	input logic in_rd,
	output logic in_empty,
	output logic overflow	// sticky, dropped host write
);

	localparam int DEPTH = `INPUT_FIFO_DEPTH;
	localparam int PW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);

	inouttraffic_pkg::word_t mem [DEPTH];
	logic [PW-1:0] wr_ptr, rd_ptr;
	logic [CW-1:0] count;
	logic do_wr, do_rd;

	assign fifo_full = (count == CW'(DEPTH));
	assign in_empty = (count == '0);
	assign in_word = mem[rd_ptr];	// head word, valid when !in_empty

	assign do_wr = fifo_wr & hs_en & ~fifo_full;
	assign do_rd = in_rd & ~in_empty;

	// storage, high and low byte exchanged on the way in
	always_ff @(posedge ifclk) begin
		if (do_wr)
			mem[wr_ptr] <= {fifo_din[7:0], fifo_din[15:8]};
	end

	always_ff @(posedge ifclk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;	// depth is a power of two, wraps
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
			// host ignored fifo_full
			if (fifo_wr && hs_en && fifo_full)
				overflow <= 1'b1;
		end
	end

endmodule

// ==== hw/pkt_comm/pkt_parser.sv ====
`timescale 1ns/1ns
`include "inouttraffic_cfg.svh"

module pkt_parser (
	input logic ifclk,
	input logic rst_n,
	input inouttraffic_pkg::word_t in_word,
	input logic in_empty,
	output logic in_rd,
	input logic out_prog_full,	// output stage low on room
	output inouttraffic_pkg::word_t pay_word,
	output logic pay_valid,
	output logic pay_last,
	output logic pkt_error,	// sticky
	output inouttraffic_pkg::byte_t pkt_count
);

	inouttraffic_pkg::parser_state_e state;
	inouttraffic_pkg::pkt_len_t remain;	// words left in packet
	inouttraffic_pkg::byte_t hdr_type;
	inouttraffic_pkg::pkt_len_t hdr_len;
	logic pop;
	logic last_word;

	// header layout after byte swap
	assign hdr_type = in_word[15:8];
	assign hdr_len = in_word[7:0];

	// pop whenever there is data and room downstream, in every state
	assign pop = ~in_empty & ~out_prog_full;
	assign in_rd = pop;
	assign last_word = (remain == inouttraffic_pkg::pkt_len_t'(1));

	// ********************
	// framing fsm
	// ********************
	always_ff @(posedge ifclk or negedge rst_n) begin
		if (!rst_n) begin
			state <= inouttraffic_pkg::PS_HEADER;
			remain <= '0;
			pay_valid <= 1'b0;
			pay_last <= 1'b0;
			pkt_error <= 1'b0;
			pkt_count <= '0;
		end else begin
			pay_valid <= 1'b0;	// single-cycle strobes
			pay_last <= 1'b0;

			// good packet done once its last word has left
			if (pay_valid && pay_last)
				pkt_count <= pkt_count + 1'b1;	// wraps mod 256

			if (pop) begin
				case (state)
					inouttraffic_pkg::PS_HEADER: begin
						remain <= hdr_len;
						if (hdr_len == '0) begin
							pkt_error <= 1'b1;	// empty packet, nothing to skip
						end else if (hdr_type != `PKT_TYPE_DATA) begin
							pkt_error <= 1'b1;
							state <= inouttraffic_pkg::PS_DISCARD;
						end else begin
							state <= inouttraffic_pkg::PS_PAYLOAD;
						end
					end
					inouttraffic_pkg::PS_PAYLOAD: begin
						pay_valid <= 1'b1;
						pay_last <= last_word;
						remain <= remain - 1'b1;
						if (last_word)
							state <= inouttraffic_pkg::PS_HEADER;
					end
					inouttraffic_pkg::PS_DISCARD: begin
						remain <= remain - 1'b1;	// pop only, nothing forwarded
						if (last_word)
							state <= inouttraffic_pkg::PS_HEADER;
					end
					default: state <= inouttraffic_pkg::PS_HEADER;
				endcase
			end
		end
	end

	// payload register
	always_ff @(posedge ifclk) begin
		if (pop && state == inouttraffic_pkg::PS_PAYLOAD)
			pay_word <= in_word;
	end

endmodule

// ==== hw/mix_core.sv ====
`timescale 1ns/1ns
`include "inouttraffic_cfg.svh"

module mix_core (
	input logic ifclk,
	input logic rst_n,
	input inouttraffic_pkg::key_t key,
	input inouttraffic_pkg::word_t pay_word,
	input logic pay_valid,
	input logic pay_last,
	output inouttraffic_pkg::word_t mix_word,
	output logic mix_valid,
	output logic mix_last
);

	localparam int ROUNDS = `MIX_ROUNDS;

	inouttraffic_pkg::word_t stage_word [ROUNDS];
	logic [ROUNDS-1:0] stage_valid;
	logic [ROUNDS-1:0] stage_last;

	// one round: rotl 3, xor key, add round number
	function automatic inouttraffic_pkg::word_t mix_round(
		input inouttraffic_pkg::word_t w,
		input inouttraffic_pkg::key_t k,
		input int unsigned rnd
	);
		inouttraffic_pkg::word_t rot;
		rot = {w[12:0], w[15:13]};
		return (rot ^ k) + inouttraffic_pkg::word_t'(rnd);	// mod 2^16
	endfunction

	// ********************
	// data path, no stall
	// ********************
	always_ff @(posedge ifclk) begin
		stage_word[0] <= mix_round(pay_word, key, 1);
		for (int i = 1; i < ROUNDS; i++)
			stage_word[i] <= mix_round(stage_word[i-1], key, i + 1);
	end

	// valid and last ride along with the data
	always_ff @(posedge ifclk or negedge rst_n) begin
		if (!rst_n) begin
			stage_valid <= '0;
			stage_last <= '0;
		end else begin
			stage_valid <= {stage_valid[ROUNDS-2:0], pay_valid};
			stage_last <= {stage_last[ROUNDS-2:0], pay_valid & pay_last};
		end
	end

	// exactly ROUNDS cycles after pay_valid
	assign mix_word = stage_word[ROUNDS-1];
	assign mix_valid = stage_valid[ROUNDS-1];
	assign mix_last = stage_last[ROUNDS-1];

endmodule

// ==== hw/hs_io/hs_output_fifo.sv ====
`timescale 1ns/1ns
`include "inouttraffic_cfg.svh"

module hs_output_fifo (
	input logic ifclk,
	input logic rst_n,
	input inouttraffic_pkg::word_t mix_word,
	input logic mix_valid,
	input logic mix_last,
	input logic out_rd,
	output inouttraffic_pkg::word_t out_dout,
	output logic out_empty,
	output logic out_prog_full	// stalls the parser
);

	localparam int DEPTH = `OUTPUT_FIFO_DEPTH;
	localparam int PW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);

	inouttraffic_pkg::word_t mem [DEPTH];
	logic [PW-1:0] wr_ptr, rd_ptr;
	logic [CW-1:0] count;
	inouttraffic_pkg::word_t csum;	// running xor of the packet
	logic trailer_pend;	// csum goes in this cycle
	logic full, do_wr, do_rd;
	inouttraffic_pkg::word_t wr_data;

	assign full = (count == CW'(DEPTH));
	assign out_empty = (count == '0);
	assign out_prog_full = ((CW'(DEPTH) - count) < CW'(`OUTPUT_PROG_FREE));
	assign out_dout = mem[rd_ptr];

	// mix word and trailer never collide, header cycle in between
	assign wr_data = trailer_pend ? csum : mix_word;
	assign do_wr = (mix_valid | trailer_pend) & ~full;
	assign do_rd = out_rd & ~out_empty;

	always_ff @(posedge ifclk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge ifclk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			csum <= '0;
			trailer_pend <= 1'b0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + CW'(do_wr) - CW'(do_rd);
			// ********************
			// checksum trailer
			// ********************
			trailer_pend <= mix_valid & mix_last;
			if (trailer_pend)
				csum <= '0;	// trailer written, next packet
			else if (mix_valid)
				csum <= csum ^ mix_word;	// last word included
		end
	end

endmodule

// ==== hw/vcr_regs.sv ====
`timescale 1ns/1ns
`include "inouttraffic_cfg.svh"

module vcr_regs (
	input logic ifclk,
	input logic rst_n,
	input inouttraffic_pkg::byte_t vcr_din,
	input logic vcr_addr_wr,	// latch address
	input logic vcr_data_wr,	// write addressed reg
	output inouttraffic_pkg::byte_t vcr_dout,
	input logic overflow,
	input logic pkt_error,
	input inouttraffic_pkg::byte_t pkt_count,
	output logic hs_en,
	output inouttraffic_pkg::key_t key
);

	inouttraffic_pkg::vcr_addr_t addr;
	inouttraffic_pkg::byte_t key_lo, key_hi;

	assign key = {key_hi, key_lo};

	// ********************
	// control registers
	// ********************
	always_ff @(posedge ifclk or negedge rst_n) begin
		if (!rst_n) begin
			addr <= '0;	// reads zero until addressed
			hs_en <= 1'b0;
			key_lo <= '0;
			key_hi <= '0;
		end else begin
			if (vcr_addr_wr)
				addr <= vcr_din;
			if (vcr_data_wr) begin
				case (addr)
					`VCR_ADDR_HS_EN: hs_en <= vcr_din[0];
					`VCR_ADDR_KEY_LO: key_lo <= vcr_din;
					`VCR_ADDR_KEY_HI: key_hi <= vcr_din;
					default: ;	// status regs are read only
				endcase
			end
		end
	end

	// read mux, combinational
	always_comb begin
		case (addr)
			`VCR_ADDR_HS_EN: vcr_dout = {7'b0, hs_en};
			`VCR_ADDR_KEY_LO: vcr_dout = key_lo;
			`VCR_ADDR_KEY_HI: vcr_dout = key_hi;
			`VCR_ADDR_STATUS: vcr_dout = {6'b0, pkt_error, overflow};
			`VCR_ADDR_PKT_COUNT: vcr_dout = pkt_count;
			default: vcr_dout = '0;	// unmapped
		endcase
	end

endmodule

// ==== hw/ztex_inouttraffic.sv ====
`timescale 1ns/1ns

module ztex_inouttraffic (
	input logic ifclk,
	input logic rst_n,

	// high-speed host link
	input inouttraffic_pkg::word_t fifo_din,
	input logic fifo_wr,
	output logic fifo_full,
	output inouttraffic_pkg::word_t out_dout,
	input logic out_rd,
	output logic out_empty,

	// vendor command/request
	input inouttraffic_pkg::byte_t vcr_din,
	input logic vcr_addr_wr,
	input logic vcr_data_wr,
	output inouttraffic_pkg::byte_t vcr_dout
);

	// input fifo -> parser
	inouttraffic_pkg::word_t in_word;
	logic in_empty, in_rd;

	// parser -> mix core
	inouttraffic_pkg::word_t pay_word;
	logic pay_valid, pay_last;

	// mix core -> output stage
	inouttraffic_pkg::word_t mix_word;
	logic mix_valid, mix_last;
	logic out_prog_full;	// back to the parser

	// status / control
	logic hs_en, overflow, pkt_error;
	inouttraffic_pkg::byte_t pkt_count;
	inouttraffic_pkg::key_t key;

	// ********************
	// host input
	// ********************
	hs_input_fifo u_hs_input_fifo (
		.ifclk(ifclk), .rst_n(rst_n), .hs_en(hs_en),
		.fifo_din(fifo_din), .fifo_wr(fifo_wr), .fifo_full(fifo_full),
		.in_word(in_word), .in_rd(in_rd), .in_empty(in_empty),
		.overflow(overflow)
	);

	pkt_parser u_pkt_parser (
		.ifclk(ifclk), .rst_n(rst_n),
		.in_word(in_word), .in_empty(in_empty), .in_rd(in_rd),
		.out_prog_full(out_prog_full),
		.pay_word(pay_word), .pay_valid(pay_valid), .pay_last(pay_last),
		.pkt_error(pkt_error), .pkt_count(pkt_count)
	);

	// ********************
	// example application
	// ********************
	mix_core u_mix_core (
		.ifclk(ifclk), .rst_n(rst_n), .key(key),
		.pay_word(pay_word), .pay_valid(pay_valid), .pay_last(pay_last),
		.mix_word(mix_word), .mix_valid(mix_valid), .mix_last(mix_last)
	);

	hs_output_fifo u_hs_output_fifo (
		.ifclk(ifclk), .rst_n(rst_n),
		.mix_word(mix_word), .mix_valid(mix_valid), .mix_last(mix_last),
		.out_rd(out_rd), .out_dout(out_dout), .out_empty(out_empty),
		.out_prog_full(out_prog_full)
	);

	// ********************
	// vcr registers
	// ********************
	vcr_regs u_vcr_regs (
		.ifclk(ifclk), .rst_n(rst_n),
		.vcr_din(vcr_din), .vcr_addr_wr(vcr_addr_wr), .vcr_data_wr(vcr_data_wr),
		.vcr_dout(vcr_dout),
		.overflow(overflow), .pkt_error(pkt_error), .pkt_count(pkt_count),
		.hs_en(hs_en), .key(key)
	);

endmodule

// ==== verif/ztex_inouttraffic_asserts.sv ====
`timescale 1ns/1ns
`include "inouttraffic_cfg.svh"

module ztex_inouttraffic_asserts (
	input logic ifclk,
	input logic rst_n,
	input logic fifo_full,
	input logic out_empty,
	input logic mix_valid,	// internal, mix core -> output stage
	input logic out_prog_full	// internal, output stage -> parser
);

	int unsigned fail_count = 0;	// read by the testbench at the end
	logic [7:0] since_rst;	// cycles since reset release, saturates
	logic [7:0] pf_run;	// consecutive cycles of out_prog_full

	always_ff @(posedge ifclk or negedge rst_n) begin
		if (!rst_n) begin
			since_rst <= '0;
			pf_run <= '0;
		end else begin
			if (since_rst != 8'hff)
				since_rst <= since_rst + 8'd1;
			if (!out_prog_full)
				pf_run <= '0;
			else if (pf_run != 8'hff)
				pf_run <= pf_run + 8'd1;
		end
	end

	// ********************
	// reset and start-up
	// ********************
	reset_flags: assert property (@(posedge ifclk) !rst_n |-> (!fifo_full && out_empty))
		else begin
			fail_count++;
			$error("fifo flags not at reset values while rst_n is low");
		end

	// pipeline cannot produce anything this early
	early_output: assert property (@(posedge ifclk) disable iff (!rst_n)
		(since_rst < 8'(`MIX_ROUNDS)) |-> out_empty)
		else begin
			fail_count++;
			$error("out_empty fell within the mix latency after reset");
		end

	// ********************
	// back-pressure
	// ********************
	// words in flight drain within MIX_ROUNDS cycles of the parser stall
	stall_drains: assert property (@(posedge ifclk) disable iff (!rst_n)
		(pf_run > 8'(`MIX_ROUNDS)) |-> !mix_valid)
		else begin
			fail_count++;
			$error("mix_valid while out_prog_full held longer than the pipeline");
		end

endmodule

bind ztex_inouttraffic ztex_inouttraffic_asserts u_asserts (
	.ifclk(ifclk), .rst_n(rst_n), .fifo_full(fifo_full), .out_empty(out_empty),
	.mix_valid(mix_valid), .out_prog_full(out_prog_full)
);

// ==== verif/tb_ztex_inouttraffic.sv ====
`timescale 1ns/1ns
`include "inouttraffic_cfg.svh"

module tb_ztex_inouttraffic;

	// test sizes that also set the timeout
	localparam int B2_PKTS = 30;
	localparam int B2_MAX_LEN = 24;
	localparam int B3_WORDS = 4;
	localparam int B4_MAX_LEN = 16;
	localparam int B5_PKTS = 3;
	localparam int B5_LEN = 40;
	localparam int FILL_MAX = 80;	// cap for the overflow fill
	localparam int TOTAL_WORDS = B2_PKTS * (B2_MAX_LEN + 1) + B3_WORDS
		+ 2 * (B4_MAX_LEN + 1) + B5_PKTS * (B5_LEN + 1) + FILL_MAX;
	localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 8 + 5000;

	logic ifclk, rst_n;
	inouttraffic_pkg::word_t fifo_din, out_dout;
	logic fifo_wr, fifo_full, out_rd, out_empty;
	inouttraffic_pkg::byte_t vcr_din, vcr_dout;
	logic vcr_addr_wr, vcr_data_wr;

	inouttraffic_pkg::word_t exp_q [$];	// expected output words in order
	inouttraffic_pkg::key_t key;	// model copy of the key
	string cur_test = "reset";
	logic read_en = 1'b0;	// host reader on/off
	int unsigned cycle_count = 0;

	ztex_inouttraffic u_dut (
		.ifclk(ifclk), .rst_n(rst_n),
		.fifo_din(fifo_din), .fifo_wr(fifo_wr), .fifo_full(fifo_full),
		.out_dout(out_dout), .out_rd(out_rd), .out_empty(out_empty),
		.vcr_din(vcr_din), .vcr_addr_wr(vcr_addr_wr), .vcr_data_wr(vcr_data_wr),
		.vcr_dout(vcr_dout)
	);

	initial begin
		ifclk = 1'b0;
		forever #4 ifclk = ~ifclk;	// 125 MHz
	end

	// ********************
	// reporting
	// ********************
	task automatic stop_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input inouttraffic_pkg::word_t exp,
		input inouttraffic_pkg::word_t act);
		if (act !== exp) begin
			$display("FAIL %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_byte(input string name, input inouttraffic_pkg::byte_t exp,
		input inouttraffic_pkg::byte_t act);
		if (act !== exp) begin
			$display("FAIL %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	// ********************
	// reference model
	// ********************
	function automatic inouttraffic_pkg::word_t swap_bytes(input inouttraffic_pkg::word_t w);
		return {w[7:0], w[15:8]};
	endfunction

	function automatic inouttraffic_pkg::word_t mixed_value(input inouttraffic_pkg::word_t w,
		input inouttraffic_pkg::key_t k);
		inouttraffic_pkg::word_t v;
		v = w;
		for (int r = 1; r <= `MIX_ROUNDS; r++) begin
			v = (v << 3) | (v >> 13);	// rotate left 3
			v = (v ^ k) + inouttraffic_pkg::word_t'(r);
		end
		return v;
	endfunction

	// ********************
	// bus tasks
	// ********************
	task automatic vcr_write(input inouttraffic_pkg::vcr_addr_t a,
		input inouttraffic_pkg::byte_t d);
		@(posedge ifclk);
		vcr_din <= a;
		vcr_addr_wr <= 1'b1;
		@(posedge ifclk);
		vcr_addr_wr <= 1'b0;
		vcr_din <= d;
		vcr_data_wr <= 1'b1;
		@(posedge ifclk);
		vcr_data_wr <= 1'b0;
	endtask

	task automatic check_reg(input inouttraffic_pkg::vcr_addr_t a,
		input inouttraffic_pkg::byte_t exp);
		@(posedge ifclk);
		vcr_din <= a;
		vcr_addr_wr <= 1'b1;
		@(posedge ifclk);
		vcr_addr_wr <= 1'b0;
		@(negedge ifclk);	// read mux settled on new address
		check_byte($sformatf("%s reg %h", cur_test, a), exp, vcr_dout);
	endtask

	// one strobe on the sampling edge without a fifo_full check
	task automatic raw_write(input inouttraffic_pkg::word_t w);
		@(posedge ifclk);
		fifo_din <= w;
		fifo_wr <= 1'b1;
		@(posedge ifclk);
		fifo_wr <= 1'b0;
	endtask

	task automatic host_write(input inouttraffic_pkg::word_t w);
		@(negedge ifclk);
		while (fifo_full)
			@(negedge ifclk);
		raw_write(w);
	endtask

	// header then payload with expected words queued before each write
	task automatic send_packet(input inouttraffic_pkg::byte_t ptype, input int len,
		input bit expect_out);
		inouttraffic_pkg::word_t w, m, csum;
		csum = '0;
		host_write(swap_bytes({ptype, inouttraffic_pkg::pkt_len_t'(len)}));
		for (int i = 0; i < len; i++) begin
			w = inouttraffic_pkg::word_t'($urandom);
			m = mixed_value(swap_bytes(w), key);
			csum = csum ^ m;
			if (expect_out) begin
				exp_q.push_back(m);
				if (i == len - 1)
					exp_q.push_back(csum);	// trailer
			end
			host_write(w);
		end
	endtask

	task automatic wait_drained();
		@(negedge ifclk);
		while (exp_q.size() != 0 || !out_empty)
			@(negedge ifclk);
	endtask

	// host reader with random gaps
	initial begin : host_reader
		wait (rst_n === 1'b1);
		forever begin
			@(negedge ifclk);
			if (read_en && !out_empty && $urandom_range(3, 0) != 0) begin
				if (exp_q.size() == 0) begin
					$display("ERROR: %s: output word %h with nothing expected",
						cur_test, out_dout);
					stop_run();
				end else begin
					check_word(cur_test, exp_q.pop_front(), out_dout);
				end
				@(posedge ifclk);
				out_rd <= 1'b1;
				@(posedge ifclk);
				out_rd <= 1'b0;
			end
		end
	end

	initial begin : watchdog
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge ifclk);
			cycle_count++;
		end
		$display("ERROR: timeout after %0d cycles in test %s", cycle_count, cur_test);
		stop_run();
	end

	// ********************
	// main sequence
	// ********************
	initial begin : main_seq
		inouttraffic_pkg::byte_t k_lo, k_hi, bad_type;
		int n;
		void'($urandom(96));
		rst_n = 1'b0;
		fifo_din = '0;
		fifo_wr = 1'b0;
		out_rd = 1'b0;
		vcr_din = '0;
		vcr_addr_wr = 1'b0;
		vcr_data_wr = 1'b0;
		key = '0;
		repeat (16) @(posedge ifclk);
		rst_n <= 1'b1;
		read_en = 1'b1;

		cur_test = "registers";
		check_reg(`VCR_ADDR_STATUS, 8'h00);
		check_reg(`VCR_ADDR_PKT_COUNT, 8'h00);
		k_lo = inouttraffic_pkg::byte_t'($urandom);
		k_hi = inouttraffic_pkg::byte_t'($urandom);
		vcr_write(`VCR_ADDR_KEY_LO, k_lo);
		vcr_write(`VCR_ADDR_KEY_HI, k_hi);
		vcr_write(`VCR_ADDR_HS_EN, 8'h01);
		key = {k_hi, k_lo};
		check_reg(`VCR_ADDR_KEY_LO, k_lo);
		check_reg(`VCR_ADDR_KEY_HI, k_hi);
		check_reg(`VCR_ADDR_HS_EN, 8'h01);

		cur_test = "random packets";
		for (int p = 0; p < B2_PKTS; p++)
			send_packet(`PKT_TYPE_DATA, $urandom_range(B2_MAX_LEN, 1), 1'b1);
		wait_drained();
		check_reg(`VCR_ADDR_PKT_COUNT, 8'(B2_PKTS));

		cur_test = "input disabled";
		vcr_write(`VCR_ADDR_HS_EN, 8'h00);
		send_packet(`PKT_TYPE_DATA, B3_WORDS - 1, 1'b0);	// would give output if taken
		repeat (24) begin
			@(negedge ifclk);
			if (!out_empty) begin
				$display("ERROR: output appeared while hs_en was clear");
				stop_run();
			end
		end
		check_reg(`VCR_ADDR_STATUS, 8'h00);
		vcr_write(`VCR_ADDR_HS_EN, 8'h01);

		cur_test = "bad type";
		bad_type = inouttraffic_pkg::byte_t'($urandom_range(255, 2));
		send_packet(bad_type, $urandom_range(B4_MAX_LEN, 1), 1'b0);
		send_packet(`PKT_TYPE_DATA, $urandom_range(B4_MAX_LEN, 1), 1'b1);
		wait_drained();
		check_reg(`VCR_ADDR_STATUS, 8'h02);
		check_reg(`VCR_ADDR_PKT_COUNT, 8'(B2_PKTS + 1));

		cur_test = "back-pressure";
		read_en = 1'b0;
		fork
			for (int p = 0; p < B5_PKTS; p++)
				send_packet(`PKT_TYPE_DATA, B5_LEN, 1'b1);
			begin
				@(negedge ifclk);
				while (!fifo_full)
					@(negedge ifclk);
				read_en = 1'b1;	// host resumes
			end
		join
		wait_drained();
		check_reg(`VCR_ADDR_PKT_COUNT, 8'(B2_PKTS + 1 + B5_PKTS));

		cur_test = "overflow";
		read_en = 1'b0;
		host_write(swap_bytes({8'(`PKT_TYPE_DATA), 8'd200}));
		n = 0;
		@(negedge ifclk);
		while (!fifo_full && n < FILL_MAX) begin
			raw_write(inouttraffic_pkg::word_t'($urandom));
			n++;
			@(negedge ifclk);
		end
		if (!fifo_full) begin
			$display("ERROR: fifo_full never rose with the host not reading");
			stop_run();
		end
		raw_write(16'hdead);	// dropped since the fifo is full
		check_reg(`VCR_ADDR_STATUS, 8'h03);

		if (u_dut.u_asserts.fail_count != 0) begin
			$display("ERROR: %0d assertion failures", u_dut.u_asserts.fail_count);
			stop_run();
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

// ==== ztex_inouttraffic.f ====
+incdir+common
common/inouttraffic_pkg.sv
hw/hs_io/hs_input_fifo.sv
hw/pkt_comm/pkt_parser.sv
hw/mix_core.sv
hw/hs_io/hs_output_fifo.sv
hw/vcr_regs.sv
hw/ztex_inouttraffic.sv
verif/ztex_inouttraffic_asserts.sv
verif/tb_ztex_inouttraffic.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run tb_ztex_inouttraffic with verilator
# the run counts as passed only if the pass line shows up in sim.log

cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --assert -Wno-fatal \
	-f ztex_inouttraffic.f \
	--top-module tb_ztex_inouttraffic -o sim_tb > build.log 2>&1 \
	&& ./obj_dir/sim_tb > sim.log 2>&1

grep -q "^Simulation finished: PASS$" sim.log \
	&& { echo "run passed, see sim.log"; exit 0; } \
	|| { echo "run failed, see build.log and sim.log"; exit 1; }
